// File: hw/fsctl_pkg.sv
`default_nettype none

package fsctl_pkg;

	localparam int DATA_W = 32;
	localparam int ADDR_W = 8;
	localparam int IMG_W_BITS = 12;
	localparam int IMG_H_BITS = 12;
	localparam int BUF_IDX_W = 2;
	localparam int NUM_STREAMS = 2;
	localparam logic [DATA_W-1:0] CORE_VERSION = 32'hFF00FF00;

	// register layout
	localparam int REGS_PER_STREAM = 5;
	localparam int BMP_STRIDE = 4;
	localparam int STREAM_BIT_BASE = 4;
	localparam int PAIR_H_LSB = 16;

	typedef logic [IMG_W_BITS-1:0] img_w_t;
	typedef logic [IMG_H_BITS-1:0] img_h_t;

	typedef enum logic [ADDR_W-1:0] {
		REG_CTRL         = 0,
		REG_DST_BMP      = 1,
		REG_INT_EN       = 2,
		REG_INT_STATE    = 3,
		REG_BUF_IDX      = 4,
		REG_S0_SIZE      = 5,
		REG_S0_WIN_ORG   = 6,
		REG_S0_WIN_SIZE  = 7,
		REG_S0_DST_ORG   = 8,
		REG_S0_DST_SIZE  = 9,
		REG_S1_SIZE      = 10,
		REG_S1_WIN_ORG   = 11,
		REG_S1_WIN_SIZE  = 12,
		REG_S1_DST_ORG   = 13,
		REG_S1_DST_SIZE  = 14,
		REG_VERSION      = 255
	} reg_addr_e;

	typedef struct packed {
		logic              valid;
		reg_addr_e         addr;
		logic [DATA_W-1:0] data;
	} reg_wr_t;

	typedef struct packed {
		img_w_t left;
		img_h_t top;
		img_w_t width;
		img_h_t height;
		img_w_t right_end;
		img_h_t bottom_end;
	} rect_t;

	typedef struct packed {
		logic [1:0] dst_bmp;
		img_w_t     width;
		img_h_t     height;
		rect_t      win;
		rect_t      dst;
	} stream_cfg_t;

	typedef struct packed {
		logic                 wr_done;
		logic [BUF_IDX_W-1:0] rd_buf_idx;
	} stream_status_t;

	// ------------------------------------------------
	// field positions inside register words
	function automatic int bmp_lsb(input int n);
		return BMP_STRIDE * n;
	endfunction

	function automatic int stream_bit(input int n);
		return STREAM_BIT_BASE + BMP_STRIDE * n;
	endfunction

	function automatic img_w_t pair_w(input logic [DATA_W-1:0] word);
		return word[IMG_W_BITS-1:0];
	endfunction

	function automatic img_h_t pair_h(input logic [DATA_W-1:0] word);
		return word[PAIR_H_LSB +: IMG_H_BITS];
	endfunction

	function automatic logic [DATA_W-1:0] pack_pair(input img_w_t w, input img_h_t h);
		logic [DATA_W-1:0] word;
		word = '0;
		word[IMG_W_BITS-1:0] = w;
		word[PAIR_H_LSB +: IMG_H_BITS] = h;
		return word;
	endfunction

endpackage

`default_nettype wire

// File: hw/reg_bus_port.sv
`default_nettype none

module reg_bus_port (
	input  wire logic                         o_clk,
	input  wire logic                         o_resetn,
	input  wire logic                         i_wr_en,
	input  wire logic [fsctl_pkg::ADDR_W-1:0] i_wr_addr,
	input  wire logic [fsctl_pkg::DATA_W-1:0] i_wr_data,
	input  wire logic                         i_rd_en,
	input  wire logic [fsctl_pkg::ADDR_W-1:0] i_rd_addr,
	output fsctl_pkg::reg_wr_t                o_wr,
	output logic                              o_rd_en,
	output fsctl_pkg::reg_addr_e              o_rd_addr
);
	import fsctl_pkg::*;

	logic              wr_ok;
	logic              wr_valid_q;
	reg_addr_e         wr_addr_q;
	logic [DATA_W-1:0] wr_data_q;

	// only writable registers pass
	always_comb begin
		case (i_wr_addr)
			REG_CTRL, REG_DST_BMP, REG_INT_EN, REG_INT_STATE,
			REG_S0_SIZE, REG_S0_WIN_ORG, REG_S0_WIN_SIZE, REG_S0_DST_ORG, REG_S0_DST_SIZE,
			REG_S1_SIZE, REG_S1_WIN_ORG, REG_S1_WIN_SIZE, REG_S1_DST_ORG, REG_S1_DST_SIZE:
				wr_ok = 1'b1;
			default: wr_ok = 1'b0;
		endcase
	end

	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			wr_valid_q <= 1'b0;
			o_rd_en <= 1'b0;
		end else begin
			wr_valid_q <= i_wr_en && wr_ok;
			o_rd_en <= i_rd_en;
		end
	end

	always_ff @(posedge o_clk) begin
		wr_addr_q <= reg_addr_e'(i_wr_addr);
		wr_data_q <= i_wr_data;
		o_rd_addr <= reg_addr_e'(i_rd_addr);
	end

	assign o_wr = '{valid: wr_valid_q, addr: wr_addr_q, data: wr_data_q};

endmodule

`default_nettype wire

// File: hw/frame_sync_ctrl.sv
`default_nettype none

module frame_sync_ctrl (
	input  wire logic                     o_clk,
	input  wire logic                     o_resetn,
	input  wire fsctl_pkg::reg_wr_t       i_wr,
	input  wire logic                     i_fsync,
	output logic [fsctl_pkg::DATA_W-1:0]  o_ctrl_word,
	output logic                          o_soft_resetn,
	output logic                          o_update,
	output logic                          o_fsync
);
	import fsctl_pkg::*;

	logic soft_rst_q;
	logic cfging_q;
	logic fsync_m;
	logic fsync_s;
	logic fsync_rise;
	logic edge_q;

	// ------------------------------------------------
	// REG_CTRL, bit 0 soft reset and bit 1 configuring
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			soft_rst_q <= 1'b0;
			cfging_q <= 1'b0;
		end else if (i_wr.valid && i_wr.addr == REG_CTRL) begin
			soft_rst_q <= i_wr.data[0];
			cfging_q <= i_wr.data[1];
		end
	end

	assign o_soft_resetn = soft_rst_q;

	always_comb begin
		o_ctrl_word = '0;
		o_ctrl_word[0] = soft_rst_q;
		o_ctrl_word[1] = cfging_q;
	end

	// ------------------------------------------------
	// two flop sync, then rising edge
	assign fsync_rise = fsync_m & ~fsync_s;

	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			fsync_m <= 1'b0;
			fsync_s <= 1'b0;
			edge_q <= 1'b0;
			o_update <= 1'b0;
			o_fsync <= 1'b0;
		end else begin
			fsync_m <= i_fsync;
			fsync_s <= fsync_m;
			edge_q <= fsync_rise;
			// hold shadow values back while software is configuring
			o_update <= fsync_rise & ~cfging_q;
			o_fsync <= edge_q;
		end
	end

endmodule

`default_nettype wire

// File: hw/stream_cfg.sv
`default_nettype none

module stream_cfg #(
	parameter int STREAM_IDX = 0
) (
	input  wire logic                 o_clk,
	input  wire logic                 o_resetn,
	input  wire fsctl_pkg::reg_wr_t   i_wr,
	input  wire logic                 i_update,
	output fsctl_pkg::stream_cfg_t    o_shadow,
	output fsctl_pkg::stream_cfg_t    o_active,
	output logic                      o_soft_resetn
);
	import fsctl_pkg::*;

	localparam int BASE = int'(REG_S0_SIZE) + REGS_PER_STREAM * STREAM_IDX;
	localparam logic [ADDR_W-1:0] A_SIZE = ADDR_W'(BASE);
	localparam logic [ADDR_W-1:0] A_WIN_ORG = ADDR_W'(BASE + 1);
	localparam logic [ADDR_W-1:0] A_WIN_SIZE = ADDR_W'(BASE + 2);
	localparam logic [ADDR_W-1:0] A_DST_ORG = ADDR_W'(BASE + 3);
	localparam logic [ADDR_W-1:0] A_DST_SIZE = ADDR_W'(BASE + 4);
	localparam int BMP_LSB = BMP_STRIDE * STREAM_IDX;

	logic [1:0] bmp_q;
	img_w_t     width_q;
	img_h_t     height_q;
	img_w_t     win_left_q;
	img_h_t     win_top_q;
	img_w_t     win_width_q;
	img_h_t     win_height_q;
	img_w_t     dst_left_q;
	img_h_t     dst_top_q;
	img_w_t     dst_width_q;
	img_h_t     dst_height_q;

	// ------------------------------------------------
	// shadow registers
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			bmp_q <= '0;
			width_q <= '0;
			height_q <= '0;
			win_left_q <= '0;
			win_top_q <= '0;
			win_width_q <= '0;
			win_height_q <= '0;
			dst_left_q <= '0;
			dst_top_q <= '0;
			dst_width_q <= '0;
			dst_height_q <= '0;
		end else if (i_wr.valid) begin
			case (i_wr.addr)
				REG_DST_BMP: bmp_q <= i_wr.data[BMP_LSB +: 2];
				A_SIZE: begin
					width_q <= pair_w(i_wr.data);
					height_q <= pair_h(i_wr.data);
				end
				A_WIN_ORG: begin
					win_left_q <= pair_w(i_wr.data);
					win_top_q <= pair_h(i_wr.data);
				end
				A_WIN_SIZE: begin
					win_width_q <= pair_w(i_wr.data);
					win_height_q <= pair_h(i_wr.data);
				end
				A_DST_ORG: begin
					dst_left_q <= pair_w(i_wr.data);
					dst_top_q <= pair_h(i_wr.data);
				end
				A_DST_SIZE: begin
					dst_width_q <= pair_w(i_wr.data);
					dst_height_q <= pair_h(i_wr.data);
				end
				default: ;
			endcase
		end
	end

	// edges are left plus width, top plus height
	always_comb begin
		o_shadow.dst_bmp = bmp_q;
		o_shadow.width = width_q;
		o_shadow.height = height_q;
		o_shadow.win.left = win_left_q;
		o_shadow.win.top = win_top_q;
		o_shadow.win.width = win_width_q;
		o_shadow.win.height = win_height_q;
		o_shadow.win.right_end = win_left_q + win_width_q;
		o_shadow.win.bottom_end = win_top_q + win_height_q;
		o_shadow.dst.left = dst_left_q;
		o_shadow.dst.top = dst_top_q;
		o_shadow.dst.width = dst_width_q;
		o_shadow.dst.height = dst_height_q;
		o_shadow.dst.right_end = dst_left_q + dst_width_q;
		o_shadow.dst.bottom_end = dst_top_q + dst_height_q;
	end

	// ------------------------------------------------
	// active copy, taken on frame sync
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			o_active <= '0;
			o_soft_resetn <= 1'b0;
		end else if (i_update) begin
			o_active <= o_shadow;
			o_soft_resetn <= (bmp_q != 2'b00);
		end
	end

endmodule

`default_nettype wire

// File: hw/stream_irq.sv
`default_nettype none

module stream_irq (
	input  wire logic                                                o_clk,
	input  wire logic                                                o_resetn,
	input  wire fsctl_pkg::reg_wr_t                                  i_wr,
	input  wire fsctl_pkg::stream_status_t [fsctl_pkg::NUM_STREAMS-1:0] i_stream_status,
	output logic [fsctl_pkg::DATA_W-1:0]                             o_int_en_word,
	output logic [fsctl_pkg::DATA_W-1:0]                             o_int_state_word,
	output logic [fsctl_pkg::NUM_STREAMS-1:0]                        o_rd_en,
	output logic                                                     o_intr
);
	import fsctl_pkg::*;

	logic [NUM_STREAMS-1:0] en_q;
	logic [NUM_STREAMS-1:0] state_q;
	logic [NUM_STREAMS-1:0] done_q;
	logic [NUM_STREAMS-1:0] done_prev_q;
	logic [NUM_STREAMS-1:0] set_w;
	logic [NUM_STREAMS-1:0] clr_w;

	always_comb begin
		for (int n = 0; n < NUM_STREAMS; n++) begin
			set_w[n] = done_q[n] & ~done_prev_q[n];
			// write one to clear
			clr_w[n] = i_wr.valid && (i_wr.addr == REG_INT_STATE) && i_wr.data[stream_bit(n)];
		end
	end

	// ------------------------------------------------
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			done_q <= '0;
			done_prev_q <= '0;
			en_q <= '0;
			state_q <= '0;
			o_rd_en <= '0;
		end else begin
			for (int n = 0; n < NUM_STREAMS; n++) begin
				done_q[n] <= i_stream_status[n].wr_done;
				if (i_wr.valid && i_wr.addr == REG_INT_EN)
					en_q[n] <= i_wr.data[stream_bit(n)];
				// a new done beats a clear in the same cycle
				if (set_w[n])
					state_q[n] <= 1'b1;
				else if (clr_w[n])
					state_q[n] <= 1'b0;
			end
			done_prev_q <= done_q;
			o_rd_en <= clr_w;
		end
	end

	always_comb begin
		o_int_en_word = '0;
		o_int_state_word = '0;
		for (int n = 0; n < NUM_STREAMS; n++) begin
			o_int_en_word[stream_bit(n)] = en_q[n];
			o_int_state_word[stream_bit(n)] = state_q[n];
		end
	end

	assign o_intr = |(en_q & state_q);

endmodule

`default_nettype wire

// File: hw/reg_readback.sv
`default_nettype none

module reg_readback (
	input  wire logic                                                o_clk,
	input  wire logic                                                o_resetn,
	input  wire logic                                                i_rd_en,
	input  wire fsctl_pkg::reg_addr_e                                i_rd_addr,
	input  wire logic [fsctl_pkg::DATA_W-1:0]                        i_ctrl_word,
	input  wire fsctl_pkg::stream_cfg_t [fsctl_pkg::NUM_STREAMS-1:0]    i_shadow,
	input  wire logic [fsctl_pkg::DATA_W-1:0]                        i_int_en_word,
	input  wire logic [fsctl_pkg::DATA_W-1:0]                        i_int_state_word,
	input  wire fsctl_pkg::stream_status_t [fsctl_pkg::NUM_STREAMS-1:0] i_stream_status,
	output logic                                                     o_rd_valid,
	output logic [fsctl_pkg::DATA_W-1:0]                             o_rd_data
);
	import fsctl_pkg::*;

	logic [DATA_W-1:0] rd_word;

	// ------------------------------------------------
	// read mux
	always_comb begin
		int base;
		base = 0;
		rd_word = '0;
		case (i_rd_addr)
			REG_CTRL: rd_word = i_ctrl_word;
			REG_DST_BMP:
				for (int n = 0; n < NUM_STREAMS; n++)
					rd_word[bmp_lsb(n) +: 2] = i_shadow[n].dst_bmp;
			REG_INT_EN: rd_word = i_int_en_word;
			REG_INT_STATE: rd_word = i_int_state_word;
			REG_BUF_IDX:
				for (int n = 0; n < NUM_STREAMS; n++)
					rd_word[stream_bit(n) +: BUF_IDX_W] = i_stream_status[n].rd_buf_idx;
			REG_VERSION: rd_word = CORE_VERSION;
			default: begin
				// per stream size pairs, unmapped stays 0
				for (int n = 0; n < NUM_STREAMS; n++) begin
					base = int'(REG_S0_SIZE) + REGS_PER_STREAM * n;
					if (i_rd_addr == ADDR_W'(base))
						rd_word = pack_pair(i_shadow[n].width, i_shadow[n].height);
					else if (i_rd_addr == ADDR_W'(base + 1))
						rd_word = pack_pair(i_shadow[n].win.left, i_shadow[n].win.top);
					else if (i_rd_addr == ADDR_W'(base + 2))
						rd_word = pack_pair(i_shadow[n].win.width, i_shadow[n].win.height);
					else if (i_rd_addr == ADDR_W'(base + 3))
						rd_word = pack_pair(i_shadow[n].dst.left, i_shadow[n].dst.top);
					else if (i_rd_addr == ADDR_W'(base + 4))
						rd_word = pack_pair(i_shadow[n].dst.width, i_shadow[n].dst.height);
				end
			end
		endcase
	end

	always_ff @(posedge o_clk) begin
		if (!o_resetn)
			o_rd_valid <= 1'b0;
		else
			o_rd_valid <= i_rd_en;
	end

	always_ff @(posedge o_clk) begin
		if (i_rd_en)
			o_rd_data <= rd_word;
	end

endmodule

`default_nettype wire

// File: hw/fsctl_top.sv
`default_nettype none

module fsctl_top (
	input  wire logic                                                o_clk,
	input  wire logic                                                o_resetn,
	input  wire logic                                                i_wr_en,
	input  wire logic [fsctl_pkg::ADDR_W-1:0]                        i_wr_addr,
	input  wire logic [fsctl_pkg::DATA_W-1:0]                        i_wr_data,
	input  wire logic                                                i_rd_en,
	input  wire logic [fsctl_pkg::ADDR_W-1:0]                        i_rd_addr,
	output logic                                                     o_rd_valid,
	output logic [fsctl_pkg::DATA_W-1:0]                             o_rd_data,
	input  wire logic                                                i_fsync,
	output logic                                                     o_fsync,
	output logic                                                     o_soft_resetn,
	output logic                                                     o_intr,
	input  wire fsctl_pkg::stream_status_t [fsctl_pkg::NUM_STREAMS-1:0] i_stream_status,
	output fsctl_pkg::stream_cfg_t [fsctl_pkg::NUM_STREAMS-1:0]      o_stream_cfg,
	output logic [fsctl_pkg::NUM_STREAMS-1:0]                        o_stream_soft_resetn,
	output logic [fsctl_pkg::NUM_STREAMS-1:0]                        o_stream_rd_en
);
	import fsctl_pkg::*;

	reg_wr_t                       wr;
	logic                          rd_en;
	reg_addr_e                     rd_addr;
	logic [DATA_W-1:0]             ctrl_word;
	logic [DATA_W-1:0]             int_en_word;
	logic [DATA_W-1:0]             int_state_word;
	logic                          update;
	stream_cfg_t [NUM_STREAMS-1:0] shadow;

	reg_bus_port u_bus (
		.o_clk     (o_clk),
		.o_resetn  (o_resetn),
		.i_wr_en   (i_wr_en),
		.i_wr_addr (i_wr_addr),
		.i_wr_data (i_wr_data),
		.i_rd_en   (i_rd_en),
		.i_rd_addr (i_rd_addr),
		.o_wr      (wr),
		.o_rd_en   (rd_en),
		.o_rd_addr (rd_addr)
	);

	frame_sync_ctrl u_fsync (
		.o_clk         (o_clk),
		.o_resetn      (o_resetn),
		.i_wr          (wr),
		.i_fsync       (i_fsync),
		.o_ctrl_word   (ctrl_word),
		.o_soft_resetn (o_soft_resetn),
		.o_update      (update),
		.o_fsync       (o_fsync)
	);

	// one config block per camera stream
	for (genvar i = 0; i < NUM_STREAMS; i++) begin : g_stream
		stream_cfg #(.STREAM_IDX(i)) u_cfg (
			.o_clk         (o_clk),
			.o_resetn      (o_resetn),
			.i_wr          (wr),
			.i_update      (update),
			.o_shadow      (shadow[i]),
			.o_active      (o_stream_cfg[i]),
			.o_soft_resetn (o_stream_soft_resetn[i])
		);
	end

	stream_irq u_irq (
		.o_clk            (o_clk),
		.o_resetn         (o_resetn),
		.i_wr             (wr),
		.i_stream_status  (i_stream_status),
		.o_int_en_word    (int_en_word),
		.o_int_state_word (int_state_word),
		.o_rd_en          (o_stream_rd_en),
		.o_intr           (o_intr)
	);

	reg_readback u_rdback (
		.o_clk            (o_clk),
		.o_resetn         (o_resetn),
		.i_rd_en          (rd_en),
		.i_rd_addr        (rd_addr),
		.i_ctrl_word      (ctrl_word),
		.i_shadow         (shadow),
		.i_int_en_word    (int_en_word),
		.i_int_state_word (int_state_word),
		.i_stream_status  (i_stream_status),
		.o_rd_valid       (o_rd_valid),
		.o_rd_data        (o_rd_data)
	);

endmodule

`default_nettype wire

// File: test/fsctl_chk.sv
`default_nettype none

module fsctl_chk (
	input wire logic                              o_clk,
	input wire logic                              o_resetn,
	input wire logic                              i_rd_en,
	input wire logic                              i_wr_en,
	input wire logic [fsctl_pkg::ADDR_W-1:0]      i_wr_addr,
	input wire logic                              o_rd_valid,
	input wire logic                              o_fsync,
	input wire logic [fsctl_pkg::NUM_STREAMS-1:0] o_stream_rd_en
);
	import fsctl_pkg::*;

	logic int_state_wr;
	int   fail_cnt = 0;

	assign int_state_wr = i_wr_en && (i_wr_addr == REG_INT_STATE);

	// read data comes back two cycles after the request
	assert property (@(posedge o_clk) disable iff (!o_resetn)
		o_rd_valid == $past(i_rd_en, 2))
		else begin
			fail_cnt++;
			$error("o_rd_valid is not two cycles after i_rd_en");
		end

	assert property (@(posedge o_clk) disable iff (!o_resetn)
		o_fsync |=> !o_fsync)
		else begin
			fail_cnt++;
			$error("o_fsync high for more than one cycle");
		end

	// clear pulse only from a state register write
	assert property (@(posedge o_clk) disable iff (!o_resetn)
		(|o_stream_rd_en) |-> $past(int_state_wr, 2))
		else begin
			fail_cnt++;
			$error("o_stream_rd_en without a write to the state register");
		end

endmodule

bind fsctl_top fsctl_chk u_chk (
	.o_clk          (o_clk),
	.o_resetn       (o_resetn),
	.i_rd_en        (i_rd_en),
	.i_wr_en        (i_wr_en),
	.i_wr_addr      (i_wr_addr),
	.o_rd_valid     (o_rd_valid),
	.o_fsync        (o_fsync),
	.o_stream_rd_en (o_stream_rd_en)
);

`default_nettype wire

// File: test/tb_fsctl.sv
`default_nettype none

module tb_fsctl;
	import fsctl_pkg::*;

	localparam int TIMEOUT = 50;

	logic                              o_clk;
	logic                              o_resetn;
	logic                              wr_en;
	logic [ADDR_W-1:0]                 wr_addr;
	logic [DATA_W-1:0]                 wr_data;
	logic                              rd_en;
	logic [ADDR_W-1:0]                 rd_addr;
	logic                              rd_valid;
	logic [DATA_W-1:0]                 rd_data;
	logic                              fsync_in;
	logic                              fsync_out;
	logic                              soft_resetn;
	logic                              intr;
	stream_status_t [NUM_STREAMS-1:0]  stream_status;
	stream_cfg_t [NUM_STREAMS-1:0]     stream_cfg;
	logic [NUM_STREAMS-1:0]            stream_soft_resetn;
	logic [NUM_STREAMS-1:0]            stream_rd_en;

	// reference model
	logic [1:0]             m_ctrl;
	logic [1:0]             m_bmp [NUM_STREAMS];
	img_w_t                 m_w [NUM_STREAMS][5];
	img_h_t                 m_h [NUM_STREAMS][5];
	stream_cfg_t            m_act [NUM_STREAMS];
	logic                   m_rst [NUM_STREAMS];
	logic [NUM_STREAMS-1:0] m_en;
	logic [NUM_STREAMS-1:0] m_state;
	int                     exp_rd_cnt [NUM_STREAMS];
	int                     rd_cnt [NUM_STREAMS];

	integer seed;
	int     checks;
	int     errors;
	int     timeouts;

	fsctl_top DUT (
		.o_clk                (o_clk),
		.o_resetn             (o_resetn),
		.i_wr_en              (wr_en),
		.i_wr_addr            (wr_addr),
		.i_wr_data            (wr_data),
		.i_rd_en              (rd_en),
		.i_rd_addr            (rd_addr),
		.o_rd_valid           (rd_valid),
		.o_rd_data            (rd_data),
		.i_fsync              (fsync_in),
		.o_fsync              (fsync_out),
		.o_soft_resetn        (soft_resetn),
		.o_intr               (intr),
		.i_stream_status      (stream_status),
		.o_stream_cfg         (stream_cfg),
		.o_stream_soft_resetn (stream_soft_resetn),
		.o_stream_rd_en       (stream_rd_en)
	);

	initial begin
		o_clk = 1'b0;
		forever #2 o_clk = ~o_clk;
	end

	always @(posedge o_clk) begin
		if (o_resetn) begin
			for (int n = 0; n < NUM_STREAMS; n++)
				if (stream_rd_en[n])
					rd_cnt[n]++;
		end
	end

	// ------------------------------------------------
	// model of the register map
	task automatic update_model(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		int n;
		int k;
		if (addr == 0) begin
			m_ctrl = data[1:0];
		end else if (addr == 1) begin
			for (n = 0; n < NUM_STREAMS; n++)
				m_bmp[n] = data[4*n +: 2];
		end else if (addr == 2) begin
			for (n = 0; n < NUM_STREAMS; n++)
				m_en[n] = data[4 + 4*n];
		end else if (addr == 3) begin
			for (n = 0; n < NUM_STREAMS; n++)
				if (data[4 + 4*n]) begin
					m_state[n] = 1'b0;
					exp_rd_cnt[n]++;
				end
		end else if (addr >= 5 && addr <= 14) begin
			n = (addr - 5) / 5;
			k = (addr - 5) % 5;
			m_w[n][k] = data[11:0];
			m_h[n][k] = data[27:16];
		end
	endtask

	function automatic logic [DATA_W-1:0] expect_word(input logic [ADDR_W-1:0] addr);
		logic [DATA_W-1:0] w;
		int n;
		int k;
		w = '0;
		if (addr == 0)
			w[1:0] = m_ctrl;
		else if (addr == 1)
			for (n = 0; n < NUM_STREAMS; n++)
				w[4*n +: 2] = m_bmp[n];
		else if (addr == 2)
			for (n = 0; n < NUM_STREAMS; n++)
				w[4 + 4*n] = m_en[n];
		else if (addr == 3)
			for (n = 0; n < NUM_STREAMS; n++)
				w[4 + 4*n] = m_state[n];
		else if (addr == 4)
			for (n = 0; n < NUM_STREAMS; n++)
				w[4 + 4*n +: 2] = stream_status[n].rd_buf_idx;
		else if (addr >= 5 && addr <= 14) begin
			n = (addr - 5) / 5;
			k = (addr - 5) % 5;
			w[11:0] = m_w[n][k];
			w[27:16] = m_h[n][k];
		end else if (addr == 255)
			w = CORE_VERSION;
		return w;
	endfunction

	function automatic stream_cfg_t expected_cfg(input int n);
		stream_cfg_t c;
		c.dst_bmp = m_bmp[n];
		c.width = m_w[n][0];
		c.height = m_h[n][0];
		c.win.left = m_w[n][1];
		c.win.top = m_h[n][1];
		c.win.width = m_w[n][2];
		c.win.height = m_h[n][2];
		c.win.right_end = m_w[n][1] + m_w[n][2];
		c.win.bottom_end = m_h[n][1] + m_h[n][2];
		c.dst.left = m_w[n][3];
		c.dst.top = m_h[n][3];
		c.dst.width = m_w[n][4];
		c.dst.height = m_h[n][4];
		c.dst.right_end = m_w[n][3] + m_w[n][4];
		c.dst.bottom_end = m_h[n][3] + m_h[n][4];
		return c;
	endfunction

	// ------------------------------------------------
	task automatic compare_word(input string name, input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		wr_en = 1'b1;
		wr_addr = addr;
		wr_data = data;
		@(posedge o_clk);
		#1;
		wr_en = 1'b0;
		update_model(addr, data);
		repeat (2) begin
			@(posedge o_clk);
			#1;
		end
	endtask

	task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
		int t;
		t = 0;
		data = '0;
		rd_en = 1'b1;
		rd_addr = addr;
		@(posedge o_clk);
		#1;
		rd_en = 1'b0;
		while (!rd_valid && t < TIMEOUT) begin
			@(posedge o_clk);
			#1;
			t++;
		end
		if (!rd_valid) begin
			timeouts++;
			$display("read of address %0d never returned valid data", addr);
		end else
			data = rd_data;
		@(posedge o_clk);
		#1;
	endtask

	task automatic read_and_check(input string name, input logic [ADDR_W-1:0] addr);
		logic [DATA_W-1:0] got;
		bus_read(addr, got);
		compare_word(name, expect_word(addr), got);
	endtask

	task automatic random_shadow();
		int a;
		bus_write(REG_DST_BMP, $random(seed));
		for (a = 5; a <= 14; a++)
			bus_write(a, $random(seed));
	endtask

	// pulse i_fsync, then wait for the o_fsync cycle
	task automatic pulse_fsync();
		int t;
		t = 0;
		fsync_in = 1'b1;
		repeat (2) begin
			@(posedge o_clk);
			#1;
		end
		fsync_in = 1'b0;
		while (!fsync_out && t < TIMEOUT) begin
			@(posedge o_clk);
			#1;
			t++;
		end
		if (!fsync_out) begin
			timeouts++;
			$display("o_fsync did not pulse after i_fsync");
		end
	endtask

	task automatic check_active(input string name);
		int n;
		for (n = 0; n < NUM_STREAMS; n++) begin
			checks++;
			if (stream_cfg[n] !== m_act[n]) begin
				errors++;
				$display("MISMATCH %s stream %0d cfg expected %h actual %h",
					name, n, m_act[n], stream_cfg[n]);
			end
			compare_word(name, m_rst[n], stream_soft_resetn[n]);
		end
	endtask

	task automatic raise_wr_done(input logic [NUM_STREAMS-1:0] mask);
		int n;
		for (n = 0; n < NUM_STREAMS; n++)
			stream_status[n].wr_done = mask[n];
		@(posedge o_clk);
		#1;
		for (n = 0; n < NUM_STREAMS; n++) begin
			stream_status[n].wr_done = 1'b0;
			if (mask[n])
				m_state[n] = 1'b1;
		end
		// state sets two edges after the input
		repeat (3) begin
			@(posedge o_clk);
			#1;
		end
	endtask

	// ------------------------------------------------
	initial begin
		logic [DATA_W-1:0]      data;
		logic [ADDR_W-1:0]      addr;
		logic [NUM_STREAMS-1:0] mask;
		int r;
		int n;
		int k;
		seed = 16921;
		checks = 0;
		errors = 0;
		timeouts = 0;
		o_resetn = 1'b0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		rd_en = 1'b0;
		rd_addr = '0;
		fsync_in = 1'b0;
		stream_status = '0;
		m_ctrl = '0;
		m_en = '0;
		m_state = '0;
		for (n = 0; n < NUM_STREAMS; n++) begin
			m_bmp[n] = '0;
			m_act[n] = '0;
			m_rst[n] = 1'b0;
			exp_rd_cnt[n] = 0;
			rd_cnt[n] = 0;
			for (k = 0; k < 5; k++) begin
				m_w[n][k] = '0;
				m_h[n][k] = '0;
			end
		end
		repeat (3) @(posedge o_clk);
		#1;
		o_resetn = 1'b1;
		if (rd_valid || fsync_out || intr || soft_resetn || stream_rd_en != '0 ||
			stream_soft_resetn != '0 || stream_cfg != '0) begin
			errors++;
			$display("outputs are not inactive after reset");
		end

		// random writes and read back
		for (r = 0; r < 40; r++) begin
			addr = $unsigned($random(seed)) % 14;
			if (addr >= 4)
				addr = addr + 1;
			bus_write(addr, $random(seed));
			read_and_check("write_read", addr);
		end
		bus_write(REG_VERSION, $random(seed));
		read_and_check("version", REG_VERSION);
		bus_write(8'h20, $random(seed));
		read_and_check("unmapped", 8'h20);
		read_and_check("unmapped", 8'd15);

		// frame sync with configuring clear
		bus_write(REG_CTRL, 32'h0);
		for (r = 0; r < 5; r++) begin
			random_shadow();
			for (n = 0; n < NUM_STREAMS; n++) begin
				m_act[n] = expected_cfg(n);
				m_rst[n] = (m_bmp[n] != 2'b00);
			end
			pulse_fsync();
			check_active("fsync_update");
		end

		// configuring set holds the active copy
		bus_write(REG_CTRL, 32'h2);
		random_shadow();
		pulse_fsync();
		check_active("fsync_hold");
		bus_write(REG_CTRL, 32'h0);

		// wr_done edges with random enables
		for (r = 0; r < 8; r++) begin
			if (r % 3 == 0)
				bus_write(REG_INT_EN, $random(seed));
			mask = $random(seed);
			raise_wr_done(mask);
			compare_word("intr_set", |(m_en & m_state), intr);
			read_and_check("int_state", REG_INT_STATE);
		end

		// write one to clear
		bus_write(REG_INT_EN, 32'h110);
		raise_wr_done(2'b11);
		for (r = 0; r < NUM_STREAMS; r++) begin
			data = '0;
			data[4 + 4*r] = 1'b1;
			bus_write(REG_INT_STATE, data);
			for (n = 0; n < NUM_STREAMS; n++)
				compare_word("rd_en_pulses", exp_rd_cnt[n], rd_cnt[n]);
			compare_word("intr_clear", |(m_en & m_state), intr);
			read_and_check("int_clear", REG_INT_STATE);
		end

		// live buffer indexes and soft reset
		for (r = 0; r < 4; r++) begin
			for (n = 0; n < NUM_STREAMS; n++)
				stream_status[n].rd_buf_idx = $random(seed);
			read_and_check("buf_idx", REG_BUF_IDX);
		end
		bus_write(REG_CTRL, 32'h1);
		compare_word("soft_resetn", 1, soft_resetn);
		read_and_check("ctrl", REG_CTRL);

		$display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
			checks, errors, timeouts, DUT.u_chk.fail_cnt);
		if (errors == 0 && timeouts == 0 && DUT.u_chk.fail_cnt == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
hw/fsctl_pkg.sv
hw/reg_bus_port.sv
hw/frame_sync_ctrl.sv
hw/stream_cfg.sv
hw/stream_irq.sv
hw/reg_readback.sv
hw/fsctl_top.sv
test/fsctl_chk.sv
test/tb_fsctl.sv
